// ==== verilog.f ====
hdl/core0_pkg.sv
hdl/instr_decode.sv
hdl/alu.sv
hdl/lifo_stack.sv
hdl/data_stack.sv
hdl/loop_control.sv
hdl/pc_control.sv
hdl/send_port.sv
hdl/core0.sv
dv/program_rom.sv
dv/tb_core0.sv

// ==== Makefile ====
SIM := obj_dir/Vtb_core0
SOURCES := $(shell grep '\.sv$$' verilog.f)

.PHONY: all run clean

all: $(SIM)

$(SIM): verilog.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal -f verilog.f \
		--top-module tb_core0 --Mdir obj_dir

run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir

// ==== dv/tb_core0.sv ====
module tb_core0;

  localparam int prog_addr_width = 8;
  localparam int send_credits = 4;
  localparam int timeout_cycles = 5000;

  logic clk;
  logic reset;
  logic [prog_addr_width-1:0] prog_addr;
  logic [core0_pkg::opcode_width+core0_pkg::word_width-1:0] prog_data;
  logic out_valid;
  logic [core0_pkg::word_width-1:0] out_data;
  logic out_credit;

  logic [core0_pkg::word_width-1:0] expected [64];
  int exp_count;
  int out_idx;
  int outstanding;
  int cycle;

  core0 #(
    .prog_addr_width(prog_addr_width),
    .send_credits(send_credits)
  ) dut0 (
    .clk(clk),
    .reset(reset),
    .prog_addr(prog_addr),
    .prog_data(prog_data),
    .out_valid(out_valid),
    .out_data(out_data),
    .out_credit(out_credit)
  );

  program_rom #(
    .addr_width(prog_addr_width)
  ) rom0 (
    .clk(clk),
    .addr(prog_addr),
    .data(prog_data)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic stop_on_failure(input string why);
    $display("=== FAIL ===");
    $fatal(1, "%s", why);
  endtask

  task automatic add_expected(input logic [core0_pkg::word_width-1:0] word);
    expected[exp_count] = word;
    exp_count++;
  endtask

  // Words in the order the test program sends them
  task automatic build_expected();
    add_expected(32'd3 - 32'd10);
    add_expected(32'd7 - 32'd3);
    add_expected(32'd5 + 32'd5);
    add_expected(32'd9);
    add_expected(((32'hF0F0_1234 ^ 32'h0FF0_00FF) | 32'h0000_5A00) & 32'hFF00_FFF0);
    add_expected(32'd0 + 32'd0 + 32'd1);
    add_expected(32'hFFFF_FFFF + 32'd2);
    add_expected(32'h11);
    add_expected(32'hA1);
    add_expected(32'hA2);
    add_expected(32'hA3);
    add_expected(32'hA4);
    for (int o = 0; o < 2; o++) begin
      add_expected(32'(o));
      for (int i = 0; i < 3; i++) begin
        add_expected(32'(i));
      end
    end
    add_expected(32'd0);
    add_expected(32'h600D_F00D);
  endtask

  // One cycle of the receiver, which frees an outstanding word now and then.
  // Credits come back slower than the program sends, so the core runs dry.
  task automatic return_credit();
    @(posedge clk);
    #10;
    out_credit = (outstanding > 0) && ($urandom % 32'd8 == 32'd0);
  endtask

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (reset) begin
      out_idx <= 0;
      outstanding <= 0;
    end else begin
      if (out_valid) begin
        out_idx <= out_idx + 1;
      end
      if (out_valid && !out_credit) begin
        outstanding <= outstanding + 1;
      end else if (out_credit && !out_valid) begin
        outstanding <= outstanding - 1;
      end
    end
  end

  a_reset_quiet: assert property (@(posedge clk)
    reset && cycle > 0 |-> !out_valid && prog_addr == '0)
    else stop_on_failure("out_valid or prog_addr was active while reset was high");

  a_out_count: assert property (@(posedge clk) disable iff (reset)
    out_valid |-> out_idx < exp_count)
    else stop_on_failure("the core sent a word after the final word");

  a_out_data: assert property (@(posedge clk) disable iff (reset)
    out_valid && out_idx < exp_count |-> out_data == expected[out_idx])
    else begin
      $display("error at time %0t: word %0d is %h, expected %h", $time,
               $sampled(out_idx), $sampled(out_data), expected[$sampled(out_idx)]);
      stop_on_failure("wrong output word");
    end

  a_credit_limit: assert property (@(posedge clk) disable iff (reset)
    out_valid |-> outstanding < send_credits)
    else stop_on_failure("a word was sent while every credit was in use");

  initial begin
    int waited;
    void'($urandom(32'h4082));
    reset = 1'b1;
    out_credit = 1'b0;
    build_expected();
    repeat (8) @(posedge clk);
    #10;
    reset = 1'b0;
    waited = 0;
    while (out_idx < exp_count && waited < timeout_cycles) begin
      return_credit();
      waited++;
    end
    // Keep the core parked on op_stop so a stray extra word would show up
    repeat (20) return_credit();
    if (out_idx == exp_count) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      stop_on_failure("timed out waiting for the final word");
    end
  end

endmodule

// ==== dv/program_rom.sv ====
module program_rom #(
  parameter int addr_width = 8
) (
  input  logic                                                     clk,
  input  logic [addr_width-1:0]                                    addr,
  output logic [core0_pkg::opcode_width+core0_pkg::word_width-1:0] data
);

  localparam int depth = 2 ** addr_width;

  logic [core0_pkg::opcode_width+core0_pkg::word_width-1:0] mem [depth];
  int at;

  // Writes one instruction at the current address and moves on
  task automatic put(input core0_pkg::opcode_t op,
                     input logic [core0_pkg::word_width-1:0] imm = '0);
    mem[at] = {imm, op};
    at++;
  endtask

  initial begin
    // Unused words halt the core and carry their own address in the immediate
    for (int i = 0; i < depth; i++) begin
      mem[i] = {32'(i), core0_pkg::op_stop};
    end
    at = 0;
    // Stack movements and ALU operations, addresses 0 to 24
    put(core0_pkg::op_push, 32'd10);
    put(core0_pkg::op_push, 32'd3);
    put(core0_pkg::op_swap);
    put(core0_pkg::op_sub);
    put(core0_pkg::op_send);
    put(core0_pkg::op_push, 32'd7);
    put(core0_pkg::op_push, 32'd3);
    put(core0_pkg::op_sub);
    put(core0_pkg::op_send);
    put(core0_pkg::op_push, 32'd5);
    put(core0_pkg::op_dup);
    put(core0_pkg::op_add);
    put(core0_pkg::op_send);
    put(core0_pkg::op_push, 32'd9);
    put(core0_pkg::op_push, 32'd8);
    put(core0_pkg::op_drop);
    put(core0_pkg::op_send);
    put(core0_pkg::op_push, 32'hF0F0_1234);
    put(core0_pkg::op_push, 32'h0FF0_00FF);
    put(core0_pkg::op_xor);
    put(core0_pkg::op_push, 32'h0000_5A00);
    put(core0_pkg::op_or);
    put(core0_pkg::op_push, 32'hFF00_FFF0);
    put(core0_pkg::op_and);
    put(core0_pkg::op_send);
    // The carry out of this add must survive the op_and before op_addc
    put(core0_pkg::op_push, 32'hFFFF_FFFF);
    put(core0_pkg::op_push, 32'd2);
    put(core0_pkg::op_add);
    put(core0_pkg::op_push, 32'd0);
    put(core0_pkg::op_push, 32'd0);
    put(core0_pkg::op_and);
    put(core0_pkg::op_push, 32'd0);
    put(core0_pkg::op_addc);
    put(core0_pkg::op_send);
    put(core0_pkg::op_send);
    // Branch on zero, taken at 36 and not taken at 40
    put(core0_pkg::op_push, 32'd0);
    put(core0_pkg::op_jz, 32'd39);
    put(core0_pkg::op_push, 32'hBAD0_0BAD);
    put(core0_pkg::op_send);
    put(core0_pkg::op_push, 32'd1);
    put(core0_pkg::op_jz, 32'd43);
    put(core0_pkg::op_push, 32'h11);
    put(core0_pkg::op_send);
    put(core0_pkg::op_call, 32'h60);
    put(core0_pkg::op_push, 32'hA4);
    put(core0_pkg::op_send);
    // Outer loop body is 48 to 54, the inner one 52 to 53
    put(core0_pkg::op_push, 32'd2);
    put(core0_pkg::op_loop, 32'd55);
    put(core0_pkg::op_iter);
    put(core0_pkg::op_send);
    put(core0_pkg::op_push, 32'd3);
    put(core0_pkg::op_loop, 32'd54);
    put(core0_pkg::op_iter);
    put(core0_pkg::op_send);
    put(core0_pkg::op_nop);
    // Break as the last body word would otherwise loop back
    put(core0_pkg::op_push, 32'd4);
    put(core0_pkg::op_loop, 32'd60);
    put(core0_pkg::op_iter);
    put(core0_pkg::op_send);
    put(core0_pkg::op_break);
    put(core0_pkg::op_jump, 32'h50);
    at = 'h50;
    put(core0_pkg::op_push, 32'h600D_F00D);
    put(core0_pkg::op_send);
    put(core0_pkg::op_stop);
    at = 'h60;
    put(core0_pkg::op_push, 32'hA1);
    put(core0_pkg::op_send);
    put(core0_pkg::op_call, 32'h70);
    put(core0_pkg::op_push, 32'hA3);
    put(core0_pkg::op_send);
    put(core0_pkg::op_ret);
    at = 'h70;
    put(core0_pkg::op_push, 32'hA2);
    put(core0_pkg::op_send);
    put(core0_pkg::op_ret);
  end

  always_ff @(posedge clk) begin
    data <= mem[addr];
  end

endmodule

// ==== hdl/core0.sv ====
module core0 #(
  parameter int prog_addr_width = 8,
  parameter int dstack_depth = 16,
  parameter int cstack_depth = 4,
  parameter int lstack_depth = 3,
  parameter int send_credits = 4
) (
  input  logic                                                   clk,
  input  logic                                                   reset,
  output logic [prog_addr_width-1:0]                             prog_addr,
  input  logic [core0_pkg::opcode_width+core0_pkg::word_width-1:0] prog_data,
  output logic                                                   out_valid,
  output logic [core0_pkg::word_width-1:0]                       out_data,
  input  logic                                                   out_credit
);

  core0_pkg::opcode_t opcode;
  core0_pkg::stack_move_t stack_move;
  core0_pkg::top_src_t top_src;
  core0_pkg::alu_op_t alu_op;
  logic [core0_pkg::word_width-1:0] imm;
  logic [core0_pkg::word_width-1:0] top;
  logic [core0_pkg::word_width-1:0] second;
  logic [core0_pkg::word_width-1:0] next_top;
  logic [core0_pkg::word_width-1:0] alu_result;
  logic [core0_pkg::word_width-1:0] iterator;
  logic [prog_addr_width-1:0] imm_addr;
  logic [prog_addr_width-1:0] pc_plus_one;
  logic [prog_addr_width-1:0] restart_addr;
  logic top_zero;
  logic no_credit;
  logic store_carry;
  logic jump;
  logic take_branch;
  logic call;
  logic ret;
  logic loop_start;
  logic loop_break;
  logic send;
  logic stall;
  logic loop_back;

  assign opcode = core0_pkg::opcode_t'(prog_data[core0_pkg::opcode_width-1:0]);
  assign imm = prog_data[core0_pkg::opcode_width +: core0_pkg::word_width];
  assign imm_addr = imm[prog_addr_width-1:0];
  assign top_zero = (top == '0);

  always_comb begin
    case (top_src)
      core0_pkg::top_alu: next_top = alu_result;
      core0_pkg::top_second: next_top = second;
      core0_pkg::top_iter: next_top = iterator;
      core0_pkg::top_dup: next_top = top;
      default: next_top = imm;
    endcase
  end

  instr_decode decode (
    .opcode(opcode), .top_zero(top_zero), .no_credit(no_credit),
    .stack_move(stack_move), .top_src(top_src), .alu_op(alu_op),
    .store_carry(store_carry), .jump(jump), .take_branch(take_branch),
    .call(call), .ret(ret), .loop_start(loop_start), .loop_break(loop_break),
    .send(send), .stall(stall)
  );

  alu alu0 (
    .clk(clk), .reset(reset), .a(second), .b(top), .alu_op(alu_op),
    .store_carry(store_carry), .result(alu_result)
  );

  data_stack #(.depth(dstack_depth)) dstack (
    .clk(clk), .reset(reset), .move(stack_move), .next_top(next_top),
    .top(top), .second(second)
  );

  loop_control #(.prog_addr_width(prog_addr_width), .lstack_depth(lstack_depth)) loops (
    .clk(clk), .reset(reset), .loop_start(loop_start), .loop_break(loop_break),
    .count(top), .pc_plus_one(pc_plus_one), .body_end(imm_addr),
    .loop_back(loop_back), .restart_addr(restart_addr), .iterator(iterator)
  );

  pc_control #(.prog_addr_width(prog_addr_width), .cstack_depth(cstack_depth)) pcs (
    .clk(clk), .reset(reset), .stall(stall), .jump(jump), .take_branch(take_branch),
    .call(call), .ret(ret), .imm_addr(imm_addr), .loop_back(loop_back),
    .restart_addr(restart_addr), .pc_plus_one(pc_plus_one), .next_pc(prog_addr)
  );

  send_port #(.send_credits(send_credits)) sender (
    .clk(clk), .reset(reset), .send(send), .credit(out_credit), .data(top),
    .no_credit(no_credit), .out_valid(out_valid), .out_data(out_data)
  );

endmodule

// ==== hdl/send_port.sv ====
module send_port #(
  parameter int send_credits = 4
) (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             send,
  input  logic                             credit,
  input  logic [core0_pkg::word_width-1:0] data,
  output logic                             no_credit,
  output logic                             out_valid,
  output logic [core0_pkg::word_width-1:0] out_data
);

  localparam int cw = $clog2(send_credits + 1);

  logic [cw-1:0] credits;

  assign no_credit = (credits == '0);

  // A returned credit and a send in the same cycle cancel out
  always_ff @(posedge clk) begin
    if (reset) begin
      credits <= cw'(send_credits);
      out_valid <= 1'b0;
    end else begin
      out_valid <= send;
      if (send && !credit) begin
        credits <= credits - 1'b1;
      end else if (credit && !send) begin
        credits <= credits + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (send) begin
      out_data <= data;
    end
  end

  a_credit_bound: assert property (@(posedge clk) disable iff (reset)
    credits <= cw'(send_credits))
    else $error("receiver returned more credits than it was given");

endmodule

// ==== hdl/pc_control.sv ====
module pc_control #(
  parameter int prog_addr_width = 8,
  parameter int cstack_depth = 4
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       stall,
  input  logic                       jump,
  input  logic                       take_branch,
  input  logic                       call,
  input  logic                       ret,
  input  logic [prog_addr_width-1:0] imm_addr,
  input  logic                       loop_back,
  input  logic [prog_addr_width-1:0] restart_addr,
  output logic [prog_addr_width-1:0] pc_plus_one,
  output logic [prog_addr_width-1:0] next_pc
);

  // Address of the instruction executing this cycle
  logic [prog_addr_width-1:0] pc;
  logic [prog_addr_width-1:0] pc_inc;
  logic [prog_addr_width-1:0] return_addr;

  assign pc_inc = pc + 1'b1;

  // A stalled instruction runs again, so the address that follows it is its own.
  // This keeps loop end detection quiet while the core waits.
  assign pc_plus_one = stall ? pc : pc_inc;

  lifo_stack #(
    .width(prog_addr_width),
    .depth(cstack_depth)
  ) cstack (
    .clk(clk),
    .reset(reset),
    .push(call),
    .pop(ret),
    .insert(pc_inc),
    .top(return_addr),
    .empty(),
    .full()
  );

  always_comb begin
    if (reset) begin
      next_pc = '0;
    end else if (stall) begin
      next_pc = pc;
    end else if (ret) begin
      next_pc = return_addr;
    end else if (jump || take_branch || call) begin
      next_pc = imm_addr;
    end else if (loop_back) begin
      next_pc = restart_addr;
    end else begin
      next_pc = pc_inc;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else begin
      pc <= next_pc;
    end
  end

endmodule

// ==== hdl/loop_control.sv ====
module loop_control #(
  parameter int prog_addr_width = 8,
  parameter int lstack_depth = 3
) (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             loop_start,
  input  logic                             loop_break,
  input  logic [core0_pkg::word_width-1:0] count,
  input  logic [prog_addr_width-1:0]       pc_plus_one,
  input  logic [prog_addr_width-1:0]       body_end,
  output logic                             loop_back,
  output logic [prog_addr_width-1:0]       restart_addr,
  output logic [core0_pkg::word_width-1:0] iterator
);

  // Saved frame is active flag, index, total, start and end address
  localparam int frame_width = 1 + 2 * core0_pkg::word_width + 2 * prog_addr_width;

  logic active;
  logic [core0_pkg::word_width-1:0] index;
  logic [core0_pkg::word_width-1:0] total;
  logic [prog_addr_width-1:0] start_addr;
  logic [prog_addr_width-1:0] end_addr;
  logic [frame_width-1:0] saved;
  logic at_end;
  logic last_pass;
  logic leave;

  assign at_end = active && !loop_start && (pc_plus_one == end_addr);
  // A total of zero only matches after the index wraps, which gives 2^32 passes
  assign last_pass = (index + 1'b1) == total;
  assign leave = active && (loop_break || (at_end && last_pass));
  assign loop_back = at_end && !last_pass && !loop_break;
  assign restart_addr = start_addr;
  assign iterator = index;

  lifo_stack #(
    .width(frame_width),
    .depth(lstack_depth)
  ) lstack (
    .clk(clk),
    .reset(reset),
    .push(loop_start),
    .pop(leave),
    .insert({active, index, total, start_addr, end_addr}),
    .top(saved),
    .empty(),
    .full()
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      active <= 1'b0;
    end else if (loop_start) begin
      active <= 1'b1;
    end else if (leave) begin
      active <= saved[frame_width-1];
    end
  end

  always_ff @(posedge clk) begin
    if (loop_start) begin
      index <= '0;
      total <= count;
      start_addr <= pc_plus_one;
      end_addr <= body_end;
    end else if (leave) begin
      {index, total, start_addr, end_addr} <= saved[frame_width-2:0];
    end else if (at_end) begin
      index <= index + 1'b1;
    end
  end

endmodule

// ==== hdl/data_stack.sv ====
module data_stack #(
  parameter int depth = 16
) (
  input  logic                             clk,
  input  logic                             reset,
  input  core0_pkg::stack_move_t           move,
  input  logic [core0_pkg::word_width-1:0] next_top,
  output logic [core0_pkg::word_width-1:0] top,
  output logic [core0_pkg::word_width-1:0] second
);

  localparam int cw = $clog2(depth + 1);
  localparam int aw = $clog2(depth - 2);

  // Everything below the second word sits here
  logic [core0_pkg::word_width-1:0] deep [depth-2];
  logic [cw-1:0] count;
  logic [aw-1:0] spill_idx;
  logic [aw-1:0] fill_idx;
  logic [core0_pkg::word_width-1:0] deep_top;
  logic [1:0] operands;

  assign spill_idx = aw'(count - cw'(2));
  assign fill_idx = aw'(count - cw'(3));
  assign deep_top = (count >= cw'(3)) ? deep[fill_idx] : '0;

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (move == core0_pkg::move_push) begin
      count <= count + 1'b1;
    end else if (move == core0_pkg::move_pop || move == core0_pkg::move_pop_replace) begin
      count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    case (move)
      core0_pkg::move_push: begin
        top <= next_top;
        second <= top;
        if (count >= cw'(2)) begin
          deep[spill_idx] <= second;
        end
      end
      core0_pkg::move_pop: begin
        top <= second;
        second <= deep_top;
      end
      core0_pkg::move_replace: top <= next_top;
      core0_pkg::move_pop_replace: begin
        top <= next_top;
        second <= deep_top;
      end
      // The new top for a swap is the old second, selected outside
      core0_pkg::move_swap: begin
        top <= next_top;
        second <= top;
      end
      default: ;
    endcase
  end

  // Number of live words each movement consumes
  always_comb begin
    case (move)
      core0_pkg::move_pop, core0_pkg::move_replace: operands = 2'd1;
      core0_pkg::move_pop_replace, core0_pkg::move_swap: operands = 2'd2;
      default: operands = 2'd0;
    endcase
  end

  a_no_overflow: assert property (@(posedge clk) disable iff (reset)
    move == core0_pkg::move_push |-> count < cw'(depth))
    else $error("data stack overflow");
  a_no_underflow: assert property (@(posedge clk) disable iff (reset)
    count >= cw'(operands))
    else $error("data stack underflow");

endmodule

// ==== hdl/lifo_stack.sv ====
module lifo_stack #(
  parameter int width = 8,
  parameter int depth = 4
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             push,
  input  logic             pop,
  input  logic [width-1:0] insert,
  output logic [width-1:0] top,
  output logic             empty,
  output logic             full
);

  localparam int cw = $clog2(depth + 1);
  localparam int aw = (depth > 1) ? $clog2(depth) : 1;

  logic [width-1:0] entries [depth];
  logic [cw-1:0] count;
  logic [aw-1:0] wr_idx;
  logic [aw-1:0] rd_idx;

  assign wr_idx = aw'(count);
  assign rd_idx = aw'(count - 1'b1);
  assign empty = (count == '0);
  assign full = (count == cw'(depth));
  assign top = empty ? '0 : entries[rd_idx];

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (push && !pop) begin
      count <= count + 1'b1;
    end else if (pop && !push) begin
      count <= count - 1'b1;
    end
  end

  // Push together with pop overwrites the top entry in place
  always_ff @(posedge clk) begin
    if (push) begin
      entries[pop ? rd_idx : wr_idx] <= insert;
    end
  end

  a_no_overflow: assert property (@(posedge clk) disable iff (reset) !(push && !pop && full))
    else $error("lifo_stack push while full");
  a_no_underflow: assert property (@(posedge clk) disable iff (reset) !(pop && empty))
    else $error("lifo_stack pop while empty");

endmodule

// ==== hdl/alu.sv ====
module alu (
  input  logic                            clk,
  input  logic                            reset,
  input  logic [core0_pkg::word_width-1:0] a,
  input  logic [core0_pkg::word_width-1:0] b,
  input  core0_pkg::alu_op_t              alu_op,
  input  logic                            store_carry,
  output logic [core0_pkg::word_width-1:0] result
);

  // One extra bit on top catches the carry out, or the borrow for subtract
  logic [core0_pkg::word_width:0] wide;
  logic carry;

  always_comb begin
    case (alu_op)
      core0_pkg::alu_add:
        wide = {1'b0, a} + {1'b0, b};
      core0_pkg::alu_addc:
        wide = {1'b0, a} + {1'b0, b} + {{core0_pkg::word_width{1'b0}}, carry};
      core0_pkg::alu_sub:
        wide = {1'b0, a} - {1'b0, b};
      core0_pkg::alu_and:
        wide = {1'b0, a & b};
      core0_pkg::alu_or:
        wide = {1'b0, a | b};
      core0_pkg::alu_xor:
        wide = {1'b0, a ^ b};
      default:
        wide = '0;
    endcase
  end

  assign result = wide[core0_pkg::word_width-1:0];

  // Only arithmetic instructions touch the flag
  always_ff @(posedge clk) begin
    if (reset) begin
      carry <= 1'b0;
    end else if (store_carry) begin
      carry <= wide[core0_pkg::word_width];
    end
  end

endmodule

// ==== hdl/instr_decode.sv ====
module instr_decode (
  input  core0_pkg::opcode_t     opcode,
  input  logic                   top_zero,
  input  logic                   no_credit,
  output core0_pkg::stack_move_t stack_move,
  output core0_pkg::top_src_t    top_src,
  output core0_pkg::alu_op_t     alu_op,
  output logic                   store_carry,
  output logic                   jump,
  output logic                   take_branch,
  output logic                   call,
  output logic                   ret,
  output logic                   loop_start,
  output logic                   loop_break,
  output logic                   send,
  output logic                   stall
);

  always_comb begin
    stack_move = core0_pkg::move_hold;
    top_src = core0_pkg::top_imm;
    alu_op = core0_pkg::alu_add;
    store_carry = 1'b0;
    jump = 1'b0;
    take_branch = 1'b0;
    call = 1'b0;
    ret = 1'b0;
    loop_start = 1'b0;
    loop_break = 1'b0;
    send = 1'b0;
    stall = 1'b0;

    case (opcode)
      core0_pkg::op_push: stack_move = core0_pkg::move_push;
      core0_pkg::op_drop: stack_move = core0_pkg::move_pop;
      core0_pkg::op_dup: begin
        stack_move = core0_pkg::move_push;
        top_src = core0_pkg::top_dup;
      end
      core0_pkg::op_swap: begin
        stack_move = core0_pkg::move_swap;
        top_src = core0_pkg::top_second;
      end
      core0_pkg::op_add, core0_pkg::op_addc, core0_pkg::op_sub: begin
        stack_move = core0_pkg::move_pop_replace;
        top_src = core0_pkg::top_alu;
        store_carry = 1'b1;
        alu_op = (opcode == core0_pkg::op_add) ? core0_pkg::alu_add :
                 (opcode == core0_pkg::op_addc) ? core0_pkg::alu_addc : core0_pkg::alu_sub;
      end
      core0_pkg::op_and, core0_pkg::op_or, core0_pkg::op_xor: begin
        stack_move = core0_pkg::move_pop_replace;
        top_src = core0_pkg::top_alu;
        alu_op = (opcode == core0_pkg::op_and) ? core0_pkg::alu_and :
                 (opcode == core0_pkg::op_or) ? core0_pkg::alu_or : core0_pkg::alu_xor;
      end
      core0_pkg::op_jump: jump = 1'b1;
      core0_pkg::op_jz: begin
        stack_move = core0_pkg::move_pop;
        take_branch = top_zero;
      end
      core0_pkg::op_call: call = 1'b1;
      core0_pkg::op_ret: ret = 1'b1;
      // The loop count comes off the top of the data stack
      core0_pkg::op_loop: begin
        stack_move = core0_pkg::move_pop;
        loop_start = 1'b1;
      end
      core0_pkg::op_break: loop_break = 1'b1;
      core0_pkg::op_iter: begin
        stack_move = core0_pkg::move_push;
        top_src = core0_pkg::top_iter;
      end
      core0_pkg::op_send: begin
        stack_move = core0_pkg::move_pop;
        send = 1'b1;
        stall = no_credit;
      end
      core0_pkg::op_stop: stall = 1'b1;
      default: ;
    endcase

    // A stalled instruction repeats next cycle, so nothing may change state now
    if (stall) begin
      stack_move = core0_pkg::move_hold;
      store_carry = 1'b0;
      take_branch = 1'b0;
      loop_start = 1'b0;
      send = 1'b0;
    end
  end

endmodule

// ==== hdl/core0_pkg.sv ====
package core0_pkg;

  parameter int word_width = 32;
  parameter int opcode_width = 8;

  // A program word carries the opcode in its low bits and the immediate above it
  typedef enum logic [opcode_width-1:0] {
    op_nop   = 8'h00,
    op_push  = 8'h01,
    op_drop  = 8'h02,
    op_dup   = 8'h03,
    op_swap  = 8'h04,
    op_add   = 8'h05,
    op_addc  = 8'h06,
    op_sub   = 8'h07,
    op_and   = 8'h08,
    op_or    = 8'h09,
    op_xor   = 8'h0a,
    op_jump  = 8'h0b,
    op_jz    = 8'h0c,
    op_call  = 8'h0d,
    op_ret   = 8'h0e,
    op_loop  = 8'h0f,
    op_break = 8'h10,
    op_iter  = 8'h11,
    op_send  = 8'h12,
    op_stop  = 8'h13
  } opcode_t;

  typedef enum logic [2:0] {
    alu_add,
    alu_addc,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor
  } alu_op_t;

  // Pop_replace folds two operands into one result
  typedef enum logic [2:0] {
    move_hold,
    move_push,
    move_pop,
    move_replace,
    move_pop_replace,
    move_swap
  } stack_move_t;

  // Top_dup feeds the current top back for op_dup
  typedef enum logic [2:0] {
    top_imm,
    top_alu,
    top_second,
    top_iter,
    top_dup
  } top_src_t;

endpackage
